// ==== include/fetch_settings.svh ====
/*
  Instruction fetch settings
  Sizes and step constants shared by the fetch stage and its package
*/

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction memory size in bytes
`define FETCH_IMEM_SIZE_BYTE 4096

// Width of one instruction word
`define FETCH_INSN_W 32

// Width of the hardware loop iteration counter
`define FETCH_LOOP_CNT_W 32

// Byte distance between two consecutive instructions
`define FETCH_INSN_STEP 4

`endif

// ==== design/fetch_pkg.sv ====
/*
  Fetch package
  Address, instruction and loop types plus the control-flow opcodes
*/

`include "fetch_settings.svh"

package fetch_pkg;

  // Byte address width into the instruction memory
  localparam int IMEM_ADDR_W = $clog2(`FETCH_IMEM_SIZE_BYTE);

  typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

  // One extra bit so a loop can end just past the last word of memory
  typedef logic [IMEM_ADDR_W:0] loop_end_addr_t;

  typedef logic [`FETCH_INSN_W-1:0] insn_t;

  typedef logic [`FETCH_LOOP_CNT_W-1:0] loop_cnt_t;

  // Opcodes after which the next address is not known at fetch time
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

// ==== design/prefetch_ctrl.sv ====
/*
  Prefetch control
  Picks the next instruction memory address and checks requests against the prefetch
*/

`timescale 1ns/1ps

module prefetch_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     prefetch_en_i,

  input  logic                     fetch_req_valid_i,
  input  fetch_pkg::imem_addr_t    fetch_req_addr_i,

  input  fetch_pkg::insn_t         imem_rdata_i,
  input  logic                     imem_rvalid_i,

  input  fetch_pkg::imem_addr_t    prefetch_addr_i,
  input  fetch_pkg::imem_addr_t    seq_addr_i,

  input  logic                     prefetch_loop_active_i,
  input  fetch_pkg::loop_cnt_t     prefetch_loop_iterations_i,
  input  fetch_pkg::loop_end_addr_t prefetch_loop_end_addr_i,
  input  fetch_pkg::imem_addr_t    prefetch_loop_jump_addr_i,
  input  logic                     prefetch_ignore_errs_i,

  output fetch_pkg::imem_addr_t    imem_addr_o,
  output logic                     prefetch_load_o,
  output logic                     fetch_en_o,
  output logic                     insn_addr_err_o
);

  import fetch_pkg::*;

  logic rvalid_kill_q;
  logic rvalid_kill_d;
  logic rvalid_final;
  logic addr_match;
  logic prefetch_fail;
  logic loop_wrap;

  // Only the opcode field decides whether the word redirects control flow
  function automatic logic insn_is_branch(insn_t insn);
    return insn[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
  endfunction

  // The word arriving right after a branch belongs to an address we did not load
  assign rvalid_final = imem_rvalid_i & ~rvalid_kill_q;

  assign addr_match = (fetch_req_addr_i == prefetch_addr_i);

  // A request fails when nothing valid was prefetched or the wrong word was
  assign prefetch_fail = fetch_req_valid_i & (~rvalid_final | ~addr_match);

  assign loop_wrap = ({1'b0, prefetch_addr_i} == prefetch_loop_end_addr_i) &&
                     prefetch_loop_active_i &&
                     (prefetch_loop_iterations_i > loop_cnt_t'(1));

  always_comb begin
    imem_addr_o     = seq_addr_i;
    rvalid_kill_d   = 1'b0;
    prefetch_load_o = prefetch_en_i;

    if (!fetch_req_valid_i) begin
      // Stalled, so keep reading the word the execute stage will want next
      imem_addr_o = prefetch_addr_i;
    end else if (prefetch_fail) begin
      imem_addr_o = fetch_req_addr_i;
    end else if (insn_is_branch(imem_rdata_i)) begin
      // Target is unknown here, so stop and wait for the next request
      rvalid_kill_d   = 1'b1;
      prefetch_load_o = 1'b0;
    end else if (loop_wrap) begin
      imem_addr_o = prefetch_loop_jump_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_kill_q <= 1'b0;
    end else begin
      rvalid_kill_q <= rvalid_kill_d;
    end
  end

  assign fetch_en_o = rvalid_final & fetch_req_valid_i & addr_match;

  // The prefetcher is either right or idle, so a valid mismatch points to a fault
  assign insn_addr_err_o = rvalid_final & fetch_req_valid_i & ~prefetch_ignore_errs_i &
                           ~addr_match;

endmodule

// ==== design/prefetch_addr_counter.sv ====
/*
  Prefetch address counter
  Holds the prefetched word's address and offers the next sequential one
*/

`timescale 1ns/1ps

`include "fetch_settings.svh"

module prefetch_addr_counter (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  load_i,
  input  fetch_pkg::imem_addr_t load_addr_i,

  output fetch_pkg::imem_addr_t prefetch_addr_o,
  output fetch_pkg::imem_addr_t seq_addr_o
);

  import fetch_pkg::*;

  imem_addr_t addr_q;

  // Reloaded from whatever address the controller sent to memory
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (load_i) begin
      addr_q <= load_addr_i;
    end
  end

  assign prefetch_addr_o = addr_q;

  // Wraps at the top of memory
  assign seq_addr_o = addr_q + imem_addr_t'(`FETCH_INSN_STEP);

endmodule

// ==== design/fetch_resp_stage.sv ====
/*
  Fetch response stage
  Registers the fetched word, its address and the response valid flag
*/

`timescale 1ns/1ps

module fetch_resp_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  fetch_en_i,
  input  logic                  fetch_req_valid_i,
  input  logic                  fetch_resp_clear_i,

  input  fetch_pkg::insn_t      imem_rdata_i,
  input  fetch_pkg::imem_addr_t prefetch_addr_i,

  output logic                  fetch_resp_valid_o,
  output fetch_pkg::imem_addr_t fetch_resp_addr_o,
  output fetch_pkg::insn_t      fetch_resp_data_o
);

  import fetch_pkg::*;

  logic       resp_valid_q;
  logic       resp_valid_d;
  imem_addr_t resp_addr_q;
  insn_t      resp_data_q;

  // A request either hits the prefetch or leaves no response.
  // Without a request the response is kept until it is cleared.
  assign resp_valid_d = fetch_req_valid_i ? fetch_en_i :
                                            resp_valid_q & ~fetch_resp_clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= resp_valid_d;
    end
  end

  // Payload only moves on a hit, the valid flag says whether it is meaningful
  always_ff @(posedge clk_i) begin
    if (fetch_en_i) begin
      resp_addr_q <= prefetch_addr_i;
      resp_data_q <= imem_rdata_i;
    end
  end

  assign fetch_resp_valid_o = resp_valid_q;
  assign fetch_resp_addr_o  = resp_addr_q;
  assign fetch_resp_data_o  = resp_data_q;

endmodule

// ==== design/insn_fetch_unit.sv ====
/*
  Instruction fetch unit
  Prefetches one word ahead and hands it to the execute stage on a matching request
*/

`timescale 1ns/1ps

module insn_fetch_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Instruction memory, read only
  output logic                      imem_req_o,
  output fetch_pkg::imem_addr_t     imem_addr_o,
  input  fetch_pkg::insn_t          imem_rdata_i,
  input  logic                      imem_rvalid_i,

  // Request from the execute stage
  input  logic                      fetch_req_valid_i,
  input  fetch_pkg::imem_addr_t     fetch_req_addr_i,

  // Response to the execute stage
  output logic                      fetch_resp_valid_o,
  output fetch_pkg::imem_addr_t     fetch_resp_addr_o,
  output fetch_pkg::insn_t          fetch_resp_data_o,
  input  logic                      fetch_resp_clear_i,

  output logic                      insn_addr_err_o,

  input  logic                      prefetch_en_i,
  input  logic                      prefetch_loop_active_i,
  input  fetch_pkg::loop_cnt_t      prefetch_loop_iterations_i,
  input  fetch_pkg::loop_end_addr_t prefetch_loop_end_addr_i,
  input  fetch_pkg::imem_addr_t     prefetch_loop_jump_addr_i,
  input  logic                      prefetch_ignore_errs_i
);

  import fetch_pkg::*;

  logic       prefetch_load;
  logic       fetch_en;
  imem_addr_t prefetch_addr;
  imem_addr_t seq_addr;

  // Memory is read whenever the controller allows prefetching
  assign imem_req_o = prefetch_en_i;

  prefetch_ctrl prefetch_ctrl_inst (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .prefetch_en_i              (prefetch_en_i),
    .fetch_req_valid_i          (fetch_req_valid_i),
    .fetch_req_addr_i           (fetch_req_addr_i),
    .imem_rdata_i               (imem_rdata_i),
    .imem_rvalid_i              (imem_rvalid_i),
    .prefetch_addr_i            (prefetch_addr),
    .seq_addr_i                 (seq_addr),
    .prefetch_loop_active_i     (prefetch_loop_active_i),
    .prefetch_loop_iterations_i (prefetch_loop_iterations_i),
    .prefetch_loop_end_addr_i   (prefetch_loop_end_addr_i),
    .prefetch_loop_jump_addr_i  (prefetch_loop_jump_addr_i),
    .prefetch_ignore_errs_i     (prefetch_ignore_errs_i),
    .imem_addr_o                (imem_addr_o),
    .prefetch_load_o            (prefetch_load),
    .fetch_en_o                 (fetch_en),
    .insn_addr_err_o            (insn_addr_err_o)
  );

  prefetch_addr_counter prefetch_addr_counter_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .load_i          (prefetch_load),
    .load_addr_i     (imem_addr_o),
    .prefetch_addr_o (prefetch_addr),
    .seq_addr_o      (seq_addr)
  );

  fetch_resp_stage fetch_resp_stage_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_en_i         (fetch_en),
    .fetch_req_valid_i  (fetch_req_valid_i),
    .fetch_resp_clear_i (fetch_resp_clear_i),
    .imem_rdata_i       (imem_rdata_i),
    .prefetch_addr_i    (prefetch_addr),
    .fetch_resp_valid_o (fetch_resp_valid_o),
    .fetch_resp_addr_o  (fetch_resp_addr_o),
    .fetch_resp_data_o  (fetch_resp_data_o)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
  Testbench clock and reset
  100 ns clock with an active-low reset held for two cycles
*/

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== sim/insn_fetch_checker.sv ====
/*
  Fetch response checker
  Compares every valid response with the reference word and keeps the error counts
*/

`timescale 1ns/1ps

module insn_fetch_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  resp_valid_i,
  input  fetch_pkg::imem_addr_t resp_addr_i,
  input  fetch_pkg::insn_t      resp_data_i
);

  import fetch_pkg::*;

  string test_name = "none";
  int    test_errors = 0;
  int    error_count = 0;
  int    test_count = 0;

  // Address pattern in the upper bits, with branch words at two fixed addresses
  function automatic insn_t ref_insn(imem_addr_t addr);
    logic [6:0] opc;
    opc = 7'b0010011;
    if (addr == 12'h040 || addr == 12'h100) begin
      opc = OPC_BRANCH;
    end
    return {addr, addr[7:0] ^ 8'h5a, addr[6:2], opc};
  endfunction

  task automatic set_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s (%s): expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR in test %s: %s", test_name, msg);
    test_errors++;
    error_count++;
  endtask

  task automatic finish_test();
    test_count++;
    if (test_errors == 0) begin
      $display("Test %s finished: ok", test_name);
    end else begin
      $display("Test %s finished: %0d errors", test_name, test_errors);
    end
  endtask

  // Sampled on the falling edge, half a cycle after the response register moves
  always @(negedge clk_i) begin
    if (rst_ni && resp_valid_i) begin
      compare_value("response data", 32'(ref_insn(resp_addr_i)), 32'(resp_data_i));
    end
  end

endmodule

// ==== sim/tb_insn_fetch_unit.sv ====
/*
  Instruction fetch unit testbench
  Memory model, request stimulus and directed checks around the DUT
*/

`timescale 1ns/1ps

module tb_insn_fetch_unit;

  import fetch_pkg::*;

  logic           clk;
  logic           rst_n;
  logic           imem_req;
  imem_addr_t     imem_addr;
  insn_t          imem_rdata = '0;
  logic           imem_rvalid = 1'b0;
  logic           fetch_req_valid;
  imem_addr_t     fetch_req_addr;
  logic           fetch_resp_valid;
  imem_addr_t     fetch_resp_addr;
  insn_t          fetch_resp_data;
  logic           fetch_resp_clear;
  logic           insn_addr_err;
  logic           prefetch_en;
  logic           loop_active;
  loop_cnt_t      loop_iterations;
  loop_end_addr_t loop_end_addr;
  imem_addr_t     loop_jump_addr;
  logic           ignore_errs;

  int         seed;
  int         cycle_count = 0;
  int         cycles;
  int         stall_len;
  imem_addr_t hold_addr;

  tb_clock_gen clock_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  // Memory answers one cycle after each request
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imem_rvalid <= 1'b0;
    end else begin
      imem_rvalid <= imem_req;
    end
  end

  always @(posedge clk) begin
    imem_rdata <= checker_inst.ref_insn(imem_addr);
  end

  insn_fetch_unit insn_fetch_unit_inst (
    .clk_i                      (clk),
    .rst_ni                     (rst_n),
    .imem_req_o                 (imem_req),
    .imem_addr_o                (imem_addr),
    .imem_rdata_i               (imem_rdata),
    .imem_rvalid_i              (imem_rvalid),
    .fetch_req_valid_i          (fetch_req_valid),
    .fetch_req_addr_i           (fetch_req_addr),
    .fetch_resp_valid_o         (fetch_resp_valid),
    .fetch_resp_addr_o          (fetch_resp_addr),
    .fetch_resp_data_o          (fetch_resp_data),
    .fetch_resp_clear_i         (fetch_resp_clear),
    .insn_addr_err_o            (insn_addr_err),
    .prefetch_en_i              (prefetch_en),
    .prefetch_loop_active_i     (loop_active),
    .prefetch_loop_iterations_i (loop_iterations),
    .prefetch_loop_end_addr_i   (loop_end_addr),
    .prefetch_loop_jump_addr_i  (loop_jump_addr),
    .prefetch_ignore_errs_i     (ignore_errs)
  );

  insn_fetch_checker checker_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .resp_valid_i (fetch_resp_valid),
    .resp_addr_i  (fetch_resp_addr),
    .resp_data_i  (fetch_resp_data)
  );

  // Overall cycle limit in case a test loop misbehaves
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 3000) begin
      $display("Simulation stopped: cycle limit reached");
      $display("Done: errors found");
      $finish;
    end
  end

  // Called on a falling edge, keeps requesting until the word comes back
  task automatic fetch_word(input imem_addr_t addr, output int used);
    logic ok;
    ok   = 1'b0;
    used = 0;
    while (!ok && used < 20) begin
      fetch_req_valid = 1'b1;
      fetch_req_addr  = addr;
      @(negedge clk);
      used++;
      if (fetch_resp_valid && fetch_resp_addr == addr) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      checker_inst.note_failure($sformatf("no response for address %h in 20 cycles", addr));
    end
  endtask

  task automatic drive_request(input imem_addr_t addr);
    fetch_req_valid = 1'b1;
    fetch_req_addr  = addr;
    #1;
  endtask

  initial begin
    fetch_req_valid  = 1'b0;
    fetch_req_addr   = '0;
    fetch_resp_clear = 1'b0;
    prefetch_en      = 1'b1;
    loop_active      = 1'b0;
    loop_iterations  = '0;
    loop_end_addr    = '0;
    loop_jump_addr   = '0;
    ignore_errs      = 1'b0;
    seed             = 48;

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      checker_inst.note_failure("reset was never released");
    end

    checker_inst.set_test("reset");
    checker_inst.compare_value("resp valid", 32'(0), 32'(fetch_resp_valid));
    checker_inst.compare_value("addr err", 32'(0), 32'(insn_addr_err));
    checker_inst.compare_value("imem req", 32'(1), 32'(imem_req));
    prefetch_en = 1'b0;
    #1;
    checker_inst.compare_value("imem req off", 32'(0), 32'(imem_req));
    @(negedge clk);
    prefetch_en = 1'b1;
    @(negedge clk);
    checker_inst.finish_test();

    checker_inst.set_test("sequential");
    for (int i = 0; i < 8; i++) begin
      fetch_word(imem_addr_t'(4 * i), cycles);
      checker_inst.compare_value("latency", 32'(1), 32'(cycles));
    end
    checker_inst.finish_test();

    // The stream above leaves the word after its last address prefetched
    checker_inst.set_test("stall_clear");
    fetch_req_valid = 1'b0;
    hold_addr = imem_addr_t'(4 * 8);
    stall_len = 2 + ($unsigned($random(seed)) % 6);
    for (int i = 0; i < stall_len; i++) begin
      @(negedge clk);
      checker_inst.compare_value("held imem addr", 32'(hold_addr), 32'(imem_addr));
      checker_inst.compare_value("held resp valid", 32'(1), 32'(fetch_resp_valid));
    end
    fetch_resp_clear = 1'b1;
    @(negedge clk);
    fetch_resp_clear = 1'b0;
    checker_inst.compare_value("valid after clear", 32'(0), 32'(fetch_resp_valid));
    checker_inst.finish_test();

    checker_inst.set_test("jump_mismatch");
    drive_request(12'h200);
    checker_inst.compare_value("refetch addr", 32'h200, 32'(imem_addr));
    checker_inst.compare_value("addr err", 32'(1), 32'(insn_addr_err));
    @(negedge clk);
    checker_inst.compare_value("no response", 32'(0), 32'(fetch_resp_valid));
    fetch_word(12'h200, cycles);
    ignore_errs = 1'b1;
    drive_request(12'h300);
    checker_inst.compare_value("masked err", 32'(0), 32'(insn_addr_err));
    fetch_word(12'h300, cycles);
    ignore_errs = 1'b0;
    checker_inst.finish_test();

    // The word right after the branch at 0x040 must not count as valid
    checker_inst.set_test("branch");
    for (int i = 0; i < 3; i++) begin
      fetch_word(imem_addr_t'(12'h038 + 4 * i), cycles);
    end
    drive_request(12'h044);
    checker_inst.compare_value("err after branch", 32'(0), 32'(insn_addr_err));
    for (int i = 3; i < 5; i++) begin
      fetch_word(imem_addr_t'(12'h038 + 4 * i), cycles);
    end
    checker_inst.finish_test();

    checker_inst.set_test("loop");
    loop_active     = 1'b1;
    loop_iterations = 32'd2;
    loop_end_addr   = 13'h080;
    loop_jump_addr  = 12'h060;
    fetch_word(12'h078, cycles);
    fetch_word(12'h07c, cycles);
    drive_request(12'h080);
    checker_inst.compare_value("jump addr", 32'h060, 32'(imem_addr));
    @(negedge clk);
    checker_inst.compare_value("end resp valid", 32'(1), 32'(fetch_resp_valid));
    checker_inst.compare_value("end resp addr", 32'h080, 32'(fetch_resp_addr));
    fetch_word(12'h060, cycles);
    checker_inst.compare_value("jump latency", 32'(1), 32'(cycles));
    fetch_req_valid = 1'b0;
    loop_active     = 1'b0;
    @(negedge clk);
    checker_inst.finish_test();

    $display("Tests run: %0d, errors: %0d", checker_inst.test_count,
             checker_inst.error_count);
    if (checker_inst.error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== insn_fetch_unit.f ====
+incdir+include
design/fetch_pkg.sv
design/prefetch_ctrl.sv
design/prefetch_addr_counter.sv
design/fetch_resp_stage.sv
design/insn_fetch_unit.sv
sim/tb_clock_gen.sv
sim/insn_fetch_checker.sv
sim/tb_insn_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f insn_fetch_unit.f \
  --top-module tb_insn_fetch_unit -o tb_insn_fetch_unit
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/tb_insn_fetch_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "PASSED"
  exit 0
else
  echo "FAILED"
  exit 1
fi
